//--- hw/io_pkg.sv
`default_nettype none

package io_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [15:0] reg_t;

    localparam int NUM_MMR   = 4;
    localparam int RAM_WORDS = 1024;
    localparam int RAM_AW    = $clog2(RAM_WORDS);

    typedef logic [RAM_AW-1:0] ram_idx_t;

    localparam addr_t MMR_BASE = 32'h0000_1000;  // Register k sits at this plus k.

    localparam int SEG_IDX = 0;  // Seven-segment value.
    localparam int CTL_IDX = 1;  // Display control byte.
    localparam int CRX_IDX = 2;  // Cursor column.
    localparam int CRY_IDX = 3;  // Cursor row.

    // Indexed by register number.
    localparam reg_t MMR_DEFAULT [NUM_MMR] = '{16'h0000, 16'h00f7, 16'h0001, 16'h0000};

    localparam int SCAN_BITS = 4;  // Cycles per digit is 2**SCAN_BITS.

endpackage

`default_nettype wire

//--- hw/io_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface io_bus_if import io_pkg::*; ();

    logic               en;
    logic               rw;       // 1 = write.
    addr_t              addr;
    word_t              wdata;
    logic [NUM_MMR-1:0] mmr_sel;  // One-hot and already gated by en.
    logic               ram_sel;  // Gated by en.

    modport decode (
        output en, rw, addr, wdata, mmr_sel, ram_sel
    );

    modport target (
        input en, rw, addr, wdata, mmr_sel, ram_sel
    );

    modport readback (
        input en, rw, addr, wdata, mmr_sel, ram_sel
    );

endinterface

`default_nettype wire

//--- hw/io_decode.sv
`timescale 1ns/1ps
`default_nettype none

module io_decode import io_pkg::*; (
    input  var logic   en,
    input  var logic   rw,
    input  var addr_t  addr,
    input  var word_t  wdata,
    io_bus_if.decode   bus
);

    logic ram_hit;
    logic [NUM_MMR-1:0] mmr_hit;

    // Pass the raw access through to every target.
    assign bus.en    = en;
    assign bus.rw    = rw;
    assign bus.addr  = addr;
    assign bus.wdata = wdata;

    assign ram_hit = addr < addr_t'(RAM_WORDS);  // Low range is scratch RAM.

    always_comb begin
        for (int k = 0; k < NUM_MMR; k++) begin
            mmr_hit[k] = addr == MMR_BASE + addr_t'(k);
        end
    end

    // Selects carry the enable so targets need not test it.
    assign bus.ram_sel = en && ram_hit;
    assign bus.mmr_sel = en ? mmr_hit : '0;

endmodule

`default_nettype wire

//--- hw/mmr.sv
`timescale 1ns/1ps
`default_nettype none

module mmr import io_pkg::*; #(
    parameter int IDX = 0
) (
    input  var logic  clk,
    input  var logic  arst_n,
    io_bus_if.target  bus,
    output reg_t      val
);

    logic wr;

    assign wr = bus.mmr_sel[IDX] && bus.rw;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            val <= MMR_DEFAULT[IDX];
        end else if (wr) begin
            val <= bus.wdata[$bits(reg_t)-1:0];  // Upper bits are dropped.
        end
    end

endmodule

`default_nettype wire

//--- hw/scratch_ram.sv
`timescale 1ns/1ps
`default_nettype none

module scratch_ram import io_pkg::*; (
    input  var logic  clk,
    io_bus_if.target  bus,
    output word_t     q
);

    word_t    mem [RAM_WORDS];
    ram_idx_t idx;

    assign idx = bus.addr[RAM_AW-1:0];

    // Read data only moves on a selected read, so q holds between reads.
    always_ff @(posedge clk) begin
        if (bus.ram_sel) begin
            if (bus.rw) begin
                mem[idx] <= bus.wdata;
            end else begin
                q <= mem[idx];
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/io_readback.sv
`timescale 1ns/1ps
`default_nettype none

module io_readback import io_pkg::*; (
    input  var logic   clk,
    input  var logic   arst_n,
    io_bus_if.readback bus,
    input  var reg_t   regs [NUM_MMR],
    input  var word_t  ram_q,
    output word_t      rdata
);

    typedef enum logic [1:0] {
        RD_NONE,
        RD_RAM,
        RD_MMR
    } rd_kind_e;

    rd_kind_e kind_d;
    rd_kind_e kind_q;
    word_t    reg_sel;
    word_t    reg_q;
    logic     rd;

    assign rd = bus.en && !bus.rw;

    always_comb begin
        kind_d  = RD_NONE;  // Unmapped reads give zero.
        reg_sel = '0;
        if (bus.ram_sel) begin
            kind_d = RD_RAM;
        end
        for (int k = 0; k < NUM_MMR; k++) begin
            if (bus.mmr_sel[k]) begin
                kind_d  = RD_MMR;
                reg_sel = word_t'(regs[k]);  // Zero-extend.
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            kind_q <= RD_NONE;
        end else if (rd) begin
            kind_q <= kind_d;
        end
    end

    // Register snapshot that later writes do not disturb.
    always_ff @(posedge clk) begin
        if (rd) begin
            reg_q <= reg_sel;
        end
    end

    always_comb begin
        case (kind_q)
            RD_RAM:  rdata = ram_q;
            RD_MMR:  rdata = reg_q;
            default: rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/seg7_scan.sv
`timescale 1ns/1ps
`default_nettype none

module seg7_scan import io_pkg::*; (
    input  var logic        clk,
    input  var logic        arst_n,
    input  var reg_t        value,
    output logic [7:0]      seg,
    output logic [3:0]      an
);

    logic [SCAN_BITS+1:0] div;
    logic [1:0]           digit;
    logic [3:0]           nibble;

    // Active-low gfedcba pattern for one hex digit.
    function automatic logic [6:0] hex_font(input logic [3:0] h);
        logic [6:0] p;
        case (h)
            4'h0:    p = 7'h40;
            4'h1:    p = 7'h79;
            4'h2:    p = 7'h24;
            4'h3:    p = 7'h30;
            4'h4:    p = 7'h19;
            4'h5:    p = 7'h12;
            4'h6:    p = 7'h02;
            4'h7:    p = 7'h78;
            4'h8:    p = 7'h00;
            4'h9:    p = 7'h10;
            4'ha:    p = 7'h08;
            4'hb:    p = 7'h03;
            4'hc:    p = 7'h46;
            4'hd:    p = 7'h21;
            4'he:    p = 7'h06;
            default: p = 7'h0e;
        endcase
        return p;
    endfunction

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            div <= '0;
        end else begin
            div <= div + 1'b1;  // Free running.
        end
    end

    assign digit  = div[SCAN_BITS+1:SCAN_BITS];
    assign nibble = value[{digit, 2'b00} +: 4];

    // Both patterns come from the same divider bits.
    assign seg = {1'b1, hex_font(nibble)};  // Decimal point off.
    assign an  = ~(4'b0001 << digit);

endmodule

`default_nettype wire

//--- hw/tenyr_io.sv
`timescale 1ns/1ps
`default_nettype none

module tenyr_io import io_pkg::*; (
    input  var logic   clk,
    input  var logic   arst_n,
    input  var logic   en,
    input  var logic   rw,
    input  var addr_t  addr,
    input  var word_t  wdata,
    output word_t      rdata,
    output logic [7:0] seg,
    output logic [3:0] an,
    output reg_t       disp_ctl,
    output reg_t       cursor_x,
    output reg_t       cursor_y
);

    io_bus_if bus ();

    reg_t  mmr_val [NUM_MMR];
    word_t ram_q;

    io_decode i_decode (
        .en    (en),
        .rw    (rw),
        .addr  (addr),
        .wdata (wdata),
        .bus   (bus.decode)
    );

    for (genvar k = 0; k < NUM_MMR; k++) begin : g_mmr
        mmr #(
            .IDX (k)
        ) i_mmr (
            .clk    (clk),
            .arst_n (arst_n),
            .bus    (bus.target),
            .val    (mmr_val[k])
        );
    end

    scratch_ram i_ram (
        .clk (clk),
        .bus (bus.target),
        .q   (ram_q)
    );

    io_readback i_readback (
        .clk    (clk),
        .arst_n (arst_n),
        .bus    (bus.readback),
        .regs   (mmr_val),
        .ram_q  (ram_q),
        .rdata  (rdata)
    );

    seg7_scan i_seg7 (
        .clk    (clk),
        .arst_n (arst_n),
        .value  (mmr_val[SEG_IDX]),
        .seg    (seg),
        .an     (an)
    );

    // Video block attaches here.
    assign disp_ctl = mmr_val[CTL_IDX];
    assign cursor_x = mmr_val[CRX_IDX];
    assign cursor_y = mmr_val[CRY_IDX];

endmodule

`default_nettype wire

//--- bench/io_checker.sv
`timescale 1ns/1ps
`default_nettype none

module io_checker import io_pkg::*; (
    input  var logic       clk,
    input  var logic       arst_n,
    input  var logic       en,
    input  var logic       rw,
    input  var addr_t      addr,
    input  var word_t      wdata,
    input  var word_t      rdata,
    input  var logic [7:0] seg,
    input  var logic [3:0] an,
    input  var reg_t       disp_ctl,
    input  var reg_t       cursor_x,
    input  var reg_t       cursor_y,
    output int             err_cnt,
    output int             chk_cnt,
    output int             scan_cnt
);

    word_t      ram_m [RAM_WORDS];  // Unwritten words stay unknown as in the RAM.
    reg_t       reg_m [NUM_MMR];
    word_t      exp_rdata;
    logic [5:0] scan_m;
    logic [3:0] digits_seen;
    reg_t       prev_seg;
    int         seg_age;

    initial begin
        err_cnt  = 0;
        chk_cnt  = 0;
        scan_cnt = 0;
    end

    function automatic logic in_ram(input addr_t a);
        return a < addr_t'(RAM_WORDS);
    endfunction

    function automatic logic in_mmr(input addr_t a);
        return a >= MMR_BASE && a < MMR_BASE + addr_t'(NUM_MMR);
    endfunction

    // Expected read word for an address per the memory map.
    function automatic word_t expected_read(input addr_t a);
        addr_t off;
        off = a - MMR_BASE;
        if (in_ram(a)) return ram_m[a[RAM_AW-1:0]];
        if (in_mmr(a)) return word_t'(reg_m[off[$clog2(NUM_MMR)-1:0]]);
        return '0;
    endfunction

    // Lit segments gfedcba.
    function automatic logic [6:0] lit_segments(input logic [3:0] h);
        logic [6:0] lit;
        case (h)
            4'h0:    lit = 7'h3f;
            4'h1:    lit = 7'h06;
            4'h2:    lit = 7'h5b;
            4'h3:    lit = 7'h4f;
            4'h4:    lit = 7'h66;
            4'h5:    lit = 7'h6d;
            4'h6:    lit = 7'h7d;
            4'h7:    lit = 7'h07;
            4'h8:    lit = 7'h7f;
            4'h9:    lit = 7'h6f;
            4'ha:    lit = 7'h77;
            4'hb:    lit = 7'h7c;
            4'hc:    lit = 7'h39;
            4'hd:    lit = 7'h5e;
            4'he:    lit = 7'h79;
            default: lit = 7'h71;
        endcase
        return lit;
    endfunction

    // Active-low anode pattern for each digit.
    function automatic logic [3:0] active_anode(input logic [1:0] d);
        logic [3:0] a;
        case (d)
            2'd0:    a = 4'b1110;
            2'd1:    a = 4'b1101;
            2'd2:    a = 4'b1011;
            default: a = 4'b0111;
        endcase
        return a;
    endfunction

    task automatic compare(input string name, input word_t got, input word_t exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("mismatch %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // Model update on each access.
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int k = 0; k < NUM_MMR; k++) begin
                reg_m[k] <= MMR_DEFAULT[k];
            end
            exp_rdata <= '0;
            scan_m    <= '0;
        end else begin
            scan_m <= scan_m + 6'd1;
            if (en && rw) begin
                if (in_ram(addr)) begin
                    ram_m[addr[RAM_AW-1:0]] <= wdata;
                end else if (in_mmr(addr)) begin
                    reg_m[addr - MMR_BASE] <= wdata[15:0];
                end
            end else if (en) begin
                exp_rdata <= expected_read(addr);
            end
        end
    end

    // Outputs are compared mid-cycle.
    always @(negedge clk) begin
        logic [1:0] digit;
        logic [3:0] nib;
        digit = scan_m[5:4];
        nib   = reg_m[SEG_IDX][digit * 4 +: 4];
        if (!arst_n) begin
            seg_age     = 0;
            digits_seen = '0;
        end else begin
            if (!$isunknown(exp_rdata)) begin
                compare("rdata", rdata, exp_rdata);  // Unwritten RAM is skipped.
            end
            compare("disp_ctl", word_t'(disp_ctl), word_t'(reg_m[CTL_IDX]));
            compare("cursor_x", word_t'(cursor_x), word_t'(reg_m[CRX_IDX]));
            compare("cursor_y", word_t'(cursor_y), word_t'(reg_m[CRY_IDX]));
            compare("an", word_t'(an), word_t'(active_anode(digit)));
            compare("seg", word_t'(seg), word_t'({1'b1, ~lit_segments(nib)}));
            if (reg_m[SEG_IDX] !== prev_seg) begin
                seg_age     = 0;
                digits_seen = '0;
            end
            if ($countones(~an) == 1) begin
                digits_seen = digits_seen | ~an;
            end
            seg_age++;
            if (seg_age == 64) begin
                scan_cnt++;
                if (digits_seen != 4'hf) begin
                    err_cnt++;
                    $display("Display scan missed a digit within 64 cycles at %0t", $time);
                end
                seg_age     = 0;
                digits_seen = '0;
            end
        end
        prev_seg = reg_m[SEG_IDX];
    end

endmodule

`default_nettype wire

//--- bench/tb_tenyr_io.sv
`timescale 1ns/1ps
`default_nettype none

module tb_tenyr_io import io_pkg::*; ();

    localparam int N_RANDOM       = 2000;
    localparam int TIMEOUT_CYCLES = 2000 + 600 + 400;  // Random, directed, margin.

    logic       clk;
    logic       arst_n;
    logic       en;
    logic       rw;
    addr_t      addr;
    word_t      wdata;
    word_t      rdata;
    logic [7:0] seg;
    logic [3:0] an;
    reg_t       disp_ctl;
    reg_t       cursor_x;
    reg_t       cursor_y;
    int         err_cnt;
    int         chk_cnt;
    int         scan_cnt;
    int         cycles;

    tenyr_io i_dut (
        .clk      (clk),
        .arst_n   (arst_n),
        .en       (en),
        .rw       (rw),
        .addr     (addr),
        .wdata    (wdata),
        .rdata    (rdata),
        .seg      (seg),
        .an       (an),
        .disp_ctl (disp_ctl),
        .cursor_x (cursor_x),
        .cursor_y (cursor_y)
    );

    io_checker i_chk (
        .clk      (clk),
        .arst_n   (arst_n),
        .en       (en),
        .rw       (rw),
        .addr     (addr),
        .wdata    (wdata),
        .rdata    (rdata),
        .seg      (seg),
        .an       (an),
        .disp_ctl (disp_ctl),
        .cursor_x (cursor_x),
        .cursor_y (cursor_y),
        .err_cnt  (err_cnt),
        .chk_cnt  (chk_cnt),
        .scan_cnt (scan_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // One bus cycle launched on the falling edge.
    task automatic access(input logic e, input logic w, input addr_t a, input word_t d);
        @(negedge clk);
        en    <= e;
        rw    <= w;
        addr  <= a;
        wdata <= d;
    endtask

    task automatic apply_reset();
        @(negedge clk);
        arst_n <= 1'b0;
        en     <= 1'b0;
        repeat (8) @(negedge clk);
        arst_n <= 1'b1;
    endtask

    // Weighted toward RAM, the register window and unmapped space.
    function automatic addr_t random_addr();
        int unsigned pick;
        pick = $urandom_range(99);
        if (pick < 35) return addr_t'($urandom_range(63));  // Dense reuse.
        if (pick < 50) return addr_t'($urandom_range(RAM_WORDS - 1));
        if (pick < 80) return MMR_BASE + addr_t'($urandom_range(NUM_MMR - 1));
        if (pick < 85) return MMR_BASE + addr_t'(NUM_MMR) + addr_t'($urandom_range(255));
        if (pick < 90) return addr_t'(RAM_WORDS) + addr_t'($urandom_range(32'hbff));
        return $urandom();
    endfunction

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the run did not finish", TIMEOUT_CYCLES);
            $display("Counts: %0d checks, %0d errors, %0d scan windows",
                     chk_cnt, err_cnt, scan_cnt);
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'hf71e));
        cycles = 0;
        arst_n = 1'b0;
        en     = 1'b0;
        rw     = 1'b0;
        addr   = '0;
        wdata  = '0;
        repeat (8) @(negedge clk);
        arst_n <= 1'b1;

        for (int k = 0; k < NUM_MMR; k++) begin
            access(1'b1, 1'b0, MMR_BASE + addr_t'(k), '0);  // Reset defaults.
        end

        for (int i = 0; i < N_RANDOM; i++) begin
            access($urandom_range(9) != 0, 1'($urandom_range(1)), random_addr(), $urandom());
        end

        // A second reset clears rdata before any access.
        apply_reset();
        access(1'b0, 1'b0, '0, '0);
        for (int k = 0; k < NUM_MMR; k++) begin
            access(1'b1, 1'b0, MMR_BASE + addr_t'(k), '0);
        end

        // Upper half of the write data is dropped.
        for (int k = 0; k < NUM_MMR; k++) begin
            access(1'b1, 1'b1, MMR_BASE + addr_t'(k), 32'ha5a5_0000 + word_t'(k * 4919 + 1));
        end
        for (int k = 0; k < NUM_MMR; k++) begin
            access(1'b1, 1'b0, MMR_BASE + addr_t'(k), '0);
        end

        access(1'b1, 1'b1, 32'h0000_03ff, 32'h1234_5678);
        access(1'b1, 1'b0, 32'h0000_03ff, '0);
        access(1'b1, 1'b1, 32'h0000_0005, 32'h0bad_f00d);

        // Unmapped space.
        access(1'b1, 1'b1, 32'h0000_2000, 32'hffff_ffff);
        access(1'b1, 1'b0, 32'h0000_2000, '0);
        access(1'b1, 1'b1, MMR_BASE - 1, 32'h0000_7777);
        access(1'b1, 1'b0, MMR_BASE + addr_t'(NUM_MMR), '0);
        access(1'b1, 1'b0, addr_t'(RAM_WORDS), '0);

        // Nothing moves while the enable is low.
        access(1'b0, 1'b1, MMR_BASE + addr_t'(CTL_IDX), 32'h0000_ffff);
        access(1'b0, 1'b1, 32'h0000_0005, 32'hcafe_babe);
        access(1'b0, 1'b0, MMR_BASE, '0);
        access(1'b1, 1'b0, MMR_BASE + addr_t'(CTL_IDX), '0);
        access(1'b1, 1'b0, 32'h0000_0005, '0);

        access(1'b1, 1'b1, MMR_BASE + addr_t'(SEG_IDX), 32'hffff_7e19);
        repeat (70) access(1'b0, 1'b0, '0, '0);
        @(negedge clk);
        @(posedge clk);

        if (scan_cnt == 0) begin
            $display("No complete 64-cycle digit scan window was observed");
        end
        $display("Counts: %0d checks, %0d errors, %0d scan windows",
                 chk_cnt, err_cnt, scan_cnt);
        if (err_cnt == 0 && scan_cnt > 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
hw/io_pkg.sv
hw/io_bus_if.sv
hw/io_decode.sv
hw/mmr.sv
hw/scratch_ram.sv
hw/io_readback.sv
hw/seg7_scan.sv
hw/tenyr_io.sv
bench/io_checker.sv
bench/tb_tenyr_io.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator; exit status follows the result.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f tb.f --top-module tb_tenyr_io \
    -Mdir obj_dir -o sim_tenyr_io || exit 1

out="$(./obj_dir/sim_tenyr_io)"
echo "$out"
grep -qx "Verification passed" <<< "$out" && exit 0 || exit 1
